//--- design/rv_defs.svh
// RV32I word-only core; widths below are fixed by the ISA and are not meant to be changed
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ========================================
// Datapath widths
// ========================================

// Data, PC and instruction width
`define RV_XLEN 32

// Register number width
`define RV_REG_AW 5

// Word address into either memory, byte address bits 31 to 2
`define RV_WADDR_W 30

// ========================================
// Fixed encodings
// ========================================
`define RV_NOP 32'h0000_0013      // addi x0, x0, 0
`define RV_RESET_PC 32'h0000_0000

`endif

//--- design/rvPkg.sv
// Types shared by every pipeline stage; widths follow rv_defs.svh and only word accesses exist
`include "rv_defs.svh"

package rvPkg;

	// ========================================
	// Width types
	// ========================================
	typedef logic [`RV_XLEN-1:0]    word_t;     // Data, PC or instruction
	typedef logic [`RV_REG_AW-1:0]  regAddr_t;
	typedef logic [`RV_WADDR_W-1:0] wordAddr_t; // Same for both memories
	typedef logic [3:0]             aluOp_t;    // Bit 3 picks sub or sra

	// ========================================
	// Stage registers and buses
	// ========================================
	typedef struct packed {
		logic   memRead;
		logic   memWrite;
		logic   memToReg;
		logic   aluSrc;   // Operand B from immediate
		logic   regWrite;
		logic   isJump;   // Link value goes to rd
		aluOp_t aluOp;
	} ctrl_t;

	typedef struct packed {
		word_t    rs1Data;
		word_t    rs2Data;
		word_t    imm;
		word_t    pcPlus4;
		regAddr_t rd;
		regAddr_t rs1;
		regAddr_t rs2;
		ctrl_t    ctrl;
	} idEx_t;

	typedef struct packed {
		word_t    aluResult;
		word_t    storeData;
		word_t    pcPlus4;
		regAddr_t rd;
		logic     memRead;
		logic     memWrite;
		logic     memToReg;
		logic     regWrite;
		logic     isJump;
	} exMem_t;

	typedef struct packed {
		word_t    aluResult;
		word_t    loadData;
		word_t    pcPlus4;
		regAddr_t rd;
		logic     memToReg;
		logic     regWrite;
		logic     isJump;
	} memWb_t;

	// Result on its way back to the register file
	typedef struct packed {
		logic     regWrite;
		regAddr_t rd;
		word_t    data;
	} wbPort_t;

	typedef struct packed {
		logic      read;
		logic      write;
		wordAddr_t wordAddr;
		word_t     wdata;
	} dmemReq_t;

	// Nearest producer wins, x0 never forwards
	function automatic word_t fwdSelect(
		input wbPort_t  memFwd,
		input wbPort_t  wbFwd,
		input regAddr_t rs,
		input word_t    regData
	);
		if (memFwd.regWrite && memFwd.rd != '0 && memFwd.rd == rs)
			return memFwd.data;
		if (wbFwd.regWrite && wbFwd.rd != '0 && wbFwd.rd == rs)
			return wbFwd.data;
		return regData;
	endfunction

endpackage

//--- design/fetchUnit.sv
// Branches and jumps resolve in decode with no prediction; a producer still in execute costs one bubble
`timescale 1ns/100ps
`include "rv_defs.svh"

module fetchUnit (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             imemStall,
	input  logic             dmemStall,
	input  logic             jal,
	input  logic             jalr,
	input  logic             beq,
	input  logic             bne,
	input  rvPkg::word_t     idPc,
	input  rvPkg::word_t     immediate,
	input  rvPkg::regAddr_t  idRs1,
	input  rvPkg::regAddr_t  idRs2,
	input  rvPkg::word_t     rs1Data,
	input  rvPkg::word_t     rs2Data,
	input  rvPkg::regAddr_t  exRd,
	input  logic             exMemRead,
	input  logic             exRegWrite,
	input  rvPkg::wbPort_t   memFwd,
	input  rvPkg::wbPort_t   wbFwd,
	output logic             memStall,
	output logic             hazardStall,
	output logic             bubbleIdEx,
	output logic             flushIfId,
	output rvPkg::word_t     fetchPc,
	output rvPkg::word_t     pcPlus4,
	output rvPkg::wordAddr_t imemAddr
);
	rvPkg::word_t pc;
	rvPkg::word_t nextPc;
	rvPkg::word_t rs1Fwd;
	rvPkg::word_t rs2Fwd;
	rvPkg::word_t jalrTarget;
	rvPkg::word_t pcRelTarget;
	logic         takeBranch;
	logic         rs1Hit;
	logic         rs2Hit;
	logic         loadHazard;
	logic         jalrHazard;
	logic         branchHazard;

	assign memStall = imemStall | dmemStall; // Either memory freezes everything

	// ========================================
	// Hazard detection against execute
	// ========================================
	assign rs1Hit = (exRd != '0) && (exRd == idRs1);
	assign rs2Hit = (exRd != '0) && (exRd == idRs2);

	assign loadHazard   = exMemRead && (rs1Hit || rs2Hit);
	assign jalrHazard   = jalr && exRegWrite && rs1Hit;
	assign branchHazard = (beq || bne) && exRegWrite && (rs1Hit || rs2Hit);

	assign hazardStall = loadHazard | jalrHazard | branchHazard;
	assign bubbleIdEx  = hazardStall; // Decode holds while a bubble goes to execute

	// ========================================
	// Branch compare and targets
	// ========================================
	assign rs1Fwd = rvPkg::fwdSelect(memFwd, wbFwd, idRs1, rs1Data);
	assign rs2Fwd = rvPkg::fwdSelect(memFwd, wbFwd, idRs2, rs2Data);

	assign takeBranch  = (beq && rs1Fwd == rs2Fwd) || (bne && rs1Fwd != rs2Fwd);
	assign jalrTarget  = rs1Fwd + immediate;
	assign pcRelTarget = idPc + immediate;

	// Operands not ready yet means no redirect this cycle
	assign flushIfId = (jal || jalr || takeBranch) && !hazardStall;

	always_comb begin
		if (memStall || hazardStall)
			nextPc = pc;
		else if (jalr)
			nextPc = {jalrTarget[`RV_XLEN-1:1], 1'b0}; // Bit 0 dropped per ISA
		else if (jal || takeBranch)
			nextPc = pcRelTarget;
		else
			nextPc = pcPlus4;
	end

	// PC register
	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `RV_RESET_PC;
		else
			pc <= nextPc;
	end

	assign fetchPc  = pc;
	assign pcPlus4  = pc + 32'd4;
	assign imemAddr = pc[`RV_XLEN-1:2];

endmodule

//--- design/decodeStage.sv
// Decodes the RV32I subset only (ALU ops, lw, sw, beq, bne, jal, jalr); other opcodes act as NOPs
`timescale 1ns/100ps
`include "rv_defs.svh"

module decodeStage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            memStall,
	input  logic            hazardStall,
	input  logic            flushIfId,
	input  logic            bubbleIdEx,
	input  rvPkg::word_t    fetchPc,
	input  rvPkg::word_t    pcPlus4,
	input  rvPkg::word_t    imemRdata,
	input  rvPkg::word_t    rs1Data,
	input  rvPkg::word_t    rs2Data,
	output rvPkg::word_t    idPc,
	output rvPkg::word_t    immediate,
	output rvPkg::regAddr_t idRs1,
	output rvPkg::regAddr_t idRs2,
	output logic            jal,
	output logic            jalr,
	output logic            beq,
	output logic            bne,
	output rvPkg::idEx_t    idEx
);
	localparam logic [6:0] OP_R    = 7'b0110011;
	localparam logic [6:0] OP_I    = 7'b0010011;
	localparam logic [6:0] OP_LW   = 7'b0000011;
	localparam logic [6:0] OP_SW   = 7'b0100011;
	localparam logic [6:0] OP_BR   = 7'b1100011;
	localparam logic [6:0] OP_JAL  = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;

	rvPkg::word_t inst;
	rvPkg::word_t idPcPlus4;
	rvPkg::ctrl_t ctrl;
	rvPkg::idEx_t idExNext;
	logic [6:0]   opcode;
	logic [2:0]   funct3;
	logic         funct7b5;
	logic         isShift;

	// ========================================
	// IF/ID register
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			inst <= `RV_NOP;
		end else if (!(memStall || hazardStall)) begin
			inst      <= flushIfId ? `RV_NOP : imemRdata; // Wrong-path slot becomes NOP
			idPc      <= fetchPc;
			idPcPlus4 <= pcPlus4;
		end
	end

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7b5 = inst[30];
	assign idRs1    = inst[19:15];
	assign idRs2    = inst[24:20];
	assign isShift  = (funct3 == 3'b001) || (funct3 == 3'b101);

	// Control decode, aluOp stays add unless set
	always_comb begin
		ctrl = '0;
		jal  = 1'b0;
		jalr = 1'b0;
		beq  = 1'b0;
		bne  = 1'b0;
		case (opcode)
			OP_R: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = {funct7b5, funct3};
			end
			OP_I: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = {funct3 == 3'b101 && funct7b5, funct3}; // Only srai uses bit 30
			end
			OP_LW: begin
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			OP_BR: begin
				beq = (funct3 == 3'b000);
				bne = (funct3 == 3'b001);
			end
			OP_JAL: begin
				jal           = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.isJump   = 1'b1;
			end
			OP_JALR: begin
				jalr          = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.isJump   = 1'b1;
			end
			default: ;
		endcase
	end

	// Immediate generation
	always_comb begin
		case (opcode)
			OP_SW:   immediate = {{21{inst[31]}}, inst[30:25], inst[11:7]};
			OP_BR:   immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			OP_JAL:  immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			OP_I:    immediate = isShift ? {27'b0, inst[24:20]} : {{21{inst[31]}}, inst[30:20]};
			default: immediate = {{21{inst[31]}}, inst[30:20]}; // lw and jalr
		endcase
	end

	// ========================================
	// ID/EX register
	// ========================================
	assign idExNext = '{rs1Data: rs1Data, rs2Data: rs2Data, imm: immediate,
		pcPlus4: idPcPlus4, rd: inst[11:7], rs1: idRs1, rs2: idRs2, ctrl: ctrl};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idEx.ctrl <= '0;
		end else if (!memStall) begin
			idEx <= idExNext;
			if (bubbleIdEx)
				idEx.ctrl <= '0; // Bubble writes and accesses nothing
		end
	end

endmodule

//--- design/regFile.sv
// 32 x 32 register file; a write-back in the same cycle is visible on the read ports
`timescale 1ns/100ps
`include "rv_defs.svh"

module regFile (
	input  logic            clk,
	input  logic            rst_n,
	input  rvPkg::regAddr_t rs1,
	input  rvPkg::regAddr_t rs2,
	input  rvPkg::wbPort_t  wb,
	output rvPkg::word_t    rs1Data,
	output rvPkg::word_t    rs2Data
);
	localparam int NUM_REGS = 1 << `RV_REG_AW;

	rvPkg::word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb.regWrite && wb.rd != '0) begin
			regs[wb.rd] <= wb.data; // x0 never written
		end
	end

	// Write-through bypass, x0 reads zero
	assign rs1Data = (rs1 == '0) ? '0 :
		(wb.regWrite && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 :
		(wb.regWrite && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

//--- design/executeStage.sv
// Execute, memory and write-back; data memory must answer combinationally in the cycle its stall is low
`timescale 1ns/100ps
`include "rv_defs.svh"

module executeStage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            memStall,
	input  rvPkg::idEx_t    idEx,
	input  rvPkg::word_t    dmemRdata,
	output rvPkg::dmemReq_t dmemReq,
	output rvPkg::wbPort_t  memFwd,
	output rvPkg::wbPort_t  wbFwd
);
	rvPkg::exMem_t exMem;
	rvPkg::memWb_t memWb;
	rvPkg::word_t  opA;
	rvPkg::word_t  opB;
	rvPkg::word_t  rs2Fwd;
	rvPkg::word_t  aluResult;
	logic [4:0]    shamt;

	// ========================================
	// Execute
	// ========================================
	assign opA    = rvPkg::fwdSelect(memFwd, wbFwd, idEx.rs1, idEx.rs1Data);
	assign rs2Fwd = rvPkg::fwdSelect(memFwd, wbFwd, idEx.rs2, idEx.rs2Data); // Also store data
	assign opB    = idEx.ctrl.aluSrc ? idEx.imm : rs2Fwd;
	assign shamt  = opB[4:0];

	always_comb begin
		case (idEx.ctrl.aluOp[2:0])
			3'd0: aluResult = idEx.ctrl.aluOp[3] ? opA - opB : opA + opB;
			3'd1: aluResult = opA << shamt;
			3'd2: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
			3'd4: aluResult = opA ^ opB;
			3'd5: begin
				if (idEx.ctrl.aluOp[3])
					aluResult = $signed(opA) >>> shamt; // sra
				else
					aluResult = opA >> shamt;
			end
			3'd6: aluResult = opA | opB;
			3'd7: aluResult = opA & opB;
			default: aluResult = '0; // sltu not supported
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMem.memRead  <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.isJump   <= 1'b0;
		end else if (!memStall) begin
			exMem <= '{aluResult: aluResult, storeData: rs2Fwd, pcPlus4: idEx.pcPlus4,
				rd: idEx.rd, memRead: idEx.ctrl.memRead, memWrite: idEx.ctrl.memWrite,
				memToReg: idEx.ctrl.memToReg, regWrite: idEx.ctrl.regWrite,
				isJump: idEx.ctrl.isJump};
		end
	end

	// ========================================
	// Memory access
	// ========================================
	assign dmemReq = '{read: exMem.memRead, write: exMem.memWrite,
		wordAddr: exMem.aluResult[`RV_XLEN-1:2], wdata: exMem.storeData};

	// Load data forwards straight from the port
	assign memFwd.regWrite = exMem.regWrite;
	assign memFwd.rd       = exMem.rd;
	assign memFwd.data     = exMem.isJump ? exMem.pcPlus4 :
		exMem.memToReg ? dmemRdata : exMem.aluResult;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memWb.memToReg <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.isJump   <= 1'b0;
		end else if (!memStall) begin
			memWb <= '{aluResult: exMem.aluResult, loadData: dmemRdata,
				pcPlus4: exMem.pcPlus4, rd: exMem.rd, memToReg: exMem.memToReg,
				regWrite: exMem.regWrite, isJump: exMem.isJump};
		end
	end

	// ========================================
	// Write-back select
	// ========================================
	assign wbFwd.regWrite = memWb.regWrite;
	assign wbFwd.rd       = memWb.rd;
	assign wbFwd.data     = memWb.isJump ? memWb.pcPlus4 :
		memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

//--- design/riscvCore.sv
// Five-stage RV32I core; both memories answer combinationally and hold the pipeline with a stall level
`timescale 1ns/100ps

module riscvCore (
	input  logic             clk,
	input  logic             rst_n,
	output rvPkg::wordAddr_t imemAddr,
	input  rvPkg::word_t     imemRdata,
	input  logic             imemStall,
	output rvPkg::dmemReq_t  dmemReq,
	input  rvPkg::word_t     dmemRdata,
	input  logic             dmemStall
);
	// Pipeline control
	logic            memStall;
	logic            hazardStall;
	logic            bubbleIdEx;
	logic            flushIfId;

	// Fetch and decode
	rvPkg::word_t    fetchPc;
	rvPkg::word_t    pcPlus4;
	rvPkg::word_t    idPc;
	rvPkg::word_t    immediate;
	rvPkg::regAddr_t idRs1;
	rvPkg::regAddr_t idRs2;
	logic            jal;
	logic            jalr;
	logic            beq;
	logic            bne;
	rvPkg::word_t    rs1Data;
	rvPkg::word_t    rs2Data;

	// Later stages
	rvPkg::idEx_t    idEx;
	rvPkg::wbPort_t  memFwd;
	rvPkg::wbPort_t  wbFwd;

	fetchUnit uFetch (
		.clk(clk), .rst_n(rst_n), .imemStall(imemStall), .dmemStall(dmemStall),
		.jal(jal), .jalr(jalr), .beq(beq), .bne(bne),
		.idPc(idPc), .immediate(immediate), .idRs1(idRs1), .idRs2(idRs2),
		.rs1Data(rs1Data), .rs2Data(rs2Data),
		.exRd(idEx.rd), .exMemRead(idEx.ctrl.memRead), .exRegWrite(idEx.ctrl.regWrite),
		.memFwd(memFwd), .wbFwd(wbFwd),
		.memStall(memStall), .hazardStall(hazardStall), .bubbleIdEx(bubbleIdEx),
		.flushIfId(flushIfId), .fetchPc(fetchPc), .pcPlus4(pcPlus4), .imemAddr(imemAddr)
	);

	decodeStage uDecode (
		.clk(clk), .rst_n(rst_n), .memStall(memStall), .hazardStall(hazardStall),
		.flushIfId(flushIfId), .bubbleIdEx(bubbleIdEx),
		.fetchPc(fetchPc), .pcPlus4(pcPlus4), .imemRdata(imemRdata),
		.rs1Data(rs1Data), .rs2Data(rs2Data),
		.idPc(idPc), .immediate(immediate), .idRs1(idRs1), .idRs2(idRs2),
		.jal(jal), .jalr(jalr), .beq(beq), .bne(bne), .idEx(idEx)
	);

	regFile uRegs (
		.clk(clk), .rst_n(rst_n), .rs1(idRs1), .rs2(idRs2), .wb(wbFwd),
		.rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	executeStage uExec (
		.clk(clk), .rst_n(rst_n), .memStall(memStall), .idEx(idEx),
		.dmemRdata(dmemRdata), .dmemReq(dmemReq), .memFwd(memFwd), .wbFwd(wbFwd)
	);

endmodule

//--- testbench/memModel.sv
// Combinational memories, a 256-word ROM and a 64-word RAM that alias on higher address bits
`timescale 1ns/100ps

module memModel (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             stallEn,
	input  rvPkg::wordAddr_t imemAddr,
	input  rvPkg::dmemReq_t  dmemReq,
	output rvPkg::word_t     imemRdata,
	output logic             imemStall,
	output rvPkg::word_t     dmemRdata,
	output logic             dmemStall
);
	localparam int ROM_WORDS = 256;
	localparam int RAM_WORDS = 64;
	localparam int LOG_DEPTH = 64;

	integer seed;

	rvPkg::word_t     rom [ROM_WORDS]; // Written by the testbench before reset ends
	rvPkg::word_t     ram [RAM_WORDS];
	rvPkg::wordAddr_t logAddr [LOG_DEPTH];
	rvPkg::word_t     logData [LOG_DEPTH];
	int               storeCount;

	initial begin
		seed = 63181;
		imemStall <= 1'b0;
		dmemStall <= 1'b0;
		for (int i = 0; i < RAM_WORDS; i++)
			ram[i[5:0]] <= 32'hDA7A_0000 + i;
	end

	// ========================================
	// Stall injection
	// ========================================
	always @(posedge clk) begin
		if (stallEn) begin
			imemStall <= ($random(seed) & 32'd3) == 32'd0; // About one cycle in four
			dmemStall <= ($random(seed) & 32'd3) == 32'd0;
		end else begin
			imemStall <= 1'b0;
			dmemStall <= 1'b0;
		end
	end

	assign imemRdata = rom[imemAddr[7:0]];
	assign dmemRdata = dmemReq.read ? ram[dmemReq.wordAddr[5:0]] :
		32'hDEAD_BEEF; // Marker value unless a read is requested

	// Core advances only when neither port stalls
	always @(posedge clk) begin
		if (!rst_n) begin
			storeCount <= 0;
		end else if (dmemReq.write && !dmemStall && !imemStall) begin
			ram[dmemReq.wordAddr[5:0]] <= dmemReq.wdata;
			if (storeCount < LOG_DEPTH) begin
				logAddr[storeCount[5:0]] <= dmemReq.wordAddr;
				logData[storeCount[5:0]] <= dmemReq.wdata;
			end
			storeCount <= storeCount + 1;
		end
	end

endmodule

//--- testbench/coreTb.sv
// Directed tests for riscvCore; programs start at address 0 and every result is seen as a store
`timescale 1ns/100ps
`include "rv_defs.svh"

module coreTb;
	localparam int STORE_TIMEOUT = 3000; // Cycles
	localparam int SETTLE_CYCLES = 30;
	localparam int ROM_WORDS     = 256;
	localparam int OP_IMM        = 'h13;
	localparam int OP_LOAD       = 'h03;
	localparam int OP_JALR       = 'h67;

	logic             clk;
	logic             rst_n;
	logic             stallEn;
	rvPkg::wordAddr_t imemAddr;
	rvPkg::word_t     imemRdata;
	logic             imemStall;
	rvPkg::dmemReq_t  dmemReq;
	rvPkg::word_t     dmemRdata;
	logic             dmemStall;

	rvPkg::word_t     prog [$];
	rvPkg::wordAddr_t expAddr [$];
	rvPkg::word_t     expData [$];

	riscvCore DUT (
		.clk(clk), .rst_n(rst_n), .imemAddr(imemAddr), .imemRdata(imemRdata),
		.imemStall(imemStall), .dmemReq(dmemReq), .dmemRdata(dmemRdata), .dmemStall(dmemStall)
	);

	memModel mem (
		.clk(clk), .rst_n(rst_n), .stallEn(stallEn), .imemAddr(imemAddr), .dmemReq(dmemReq),
		.imemRdata(imemRdata), .imemStall(imemStall), .dmemRdata(dmemRdata),
		.dmemStall(dmemStall)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// Instruction encoders
	// ========================================
	function automatic rvPkg::word_t rType(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic rvPkg::word_t iType(input int op, input int imm, input int rs1,
		input int f3, input int rd);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic rvPkg::word_t sType(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rvPkg::word_t bType(input int f3, input int rs1, input int rs2,
		input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic rvPkg::word_t jType(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	// ========================================
	// Program building and checks
	// ========================================
	task automatic newProgram();
		prog.delete();
		expAddr.delete();
		expData.delete();
	endtask

	task automatic emit(input rvPkg::word_t inst);
		prog.push_back(inst);
	endtask

	// sw rs2 to a byte address off x0
	task automatic emitStore(input int rs2, input int addr, input rvPkg::word_t value);
		emit(sType(rs2, 0, addr));
		expAddr.push_back(rvPkg::wordAddr_t'(addr >> 2));
		expData.push_back(value);
	endtask

	// Result goes to x3, stored at the next free word
	task automatic emitAndStore(input rvPkg::word_t inst, input rvPkg::word_t value);
		emit(inst);
		emitStore(3, 4 * expData.size(), value);
	endtask

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input rvPkg::word_t got,
		input rvPkg::word_t exp);
		if (got !== exp)
			abortRun($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic checkAddr(input string name, input rvPkg::wordAddr_t got,
		input rvPkg::wordAddr_t exp);
		if (got !== exp)
			abortRun($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	// Reset, load, run until all expected stores are seen, then compare the log
	task automatic runProgram(input string name, input logic stalls);
		int cycles;
		prog.push_back(jType(0, 0)); // Park on a self loop
		@(posedge clk);
		rst_n   <= 1'b0;
		stallEn <= stalls;
		repeat (3) @(posedge clk);
		for (int i = 0; i < ROM_WORDS; i++)
			mem.rom[i[7:0]] = (i < prog.size()) ? prog[i] : `RV_NOP;
		rst_n <= 1'b1;
		cycles = 0;
		while (mem.storeCount < expData.size()) begin
			@(negedge clk);
			cycles++;
			if (cycles > STORE_TIMEOUT)
				abortRun($sformatf("%s: timed out with %0d of %0d stores seen", name,
					mem.storeCount, expData.size()));
		end
		repeat (SETTLE_CYCLES) @(negedge clk); // Nothing more may be stored
		if (mem.storeCount != expData.size())
			abortRun($sformatf("%s: %0d stores seen but only %0d expected", name,
				mem.storeCount, expData.size()));
		for (int i = 0; i < expData.size(); i++) begin
			checkAddr($sformatf("%s store %0d address", name, i), mem.logAddr[i[5:0]],
				expAddr[i]);
			checkWord($sformatf("%s store %0d data", name, i), mem.logData[i[5:0]],
				expData[i]);
		end
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic testReset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkFlag("dmemReq.read", dmemReq.read, 1'b0);
		checkFlag("dmemReq.write", dmemReq.write, 1'b0);
		checkAddr("imemAddr", imemAddr, '0);
	endtask

	task automatic testAlu(input logic stalls);
		rvPkg::word_t a;
		rvPkg::word_t b;
		a = 32'hFFFF_FFEC; // -20
		b = 32'd7;
		newProgram();
		emit(iType(OP_IMM, -20, 0, 0, 1));
		emit(iType(OP_IMM, 7, 0, 0, 2));
		emitAndStore(rType(0, 2, 1, 0, 3), a + b);
		emitAndStore(rType(32, 2, 1, 0, 3), a - b);
		emitAndStore(rType(0, 2, 1, 7, 3), a & b);
		emitAndStore(rType(0, 2, 1, 6, 3), a | b);
		emitAndStore(rType(0, 2, 1, 4, 3), a ^ b);
		emitAndStore(rType(0, 2, 1, 2, 3), {31'b0, $signed(a) < $signed(b)});
		emitAndStore(rType(0, 1, 2, 2, 3), {31'b0, $signed(b) < $signed(a)});
		emitAndStore(rType(0, 2, 2, 1, 3), b << b[4:0]);
		emitAndStore(rType(0, 2, 1, 5, 3), a >> b[4:0]);
		emitAndStore(rType(32, 2, 1, 5, 3), $unsigned($signed(a) >>> b[4:0]));
		// Immediate forms
		emitAndStore(iType(OP_IMM, 100, 1, 0, 3), a + 32'd100);
		emitAndStore(iType(OP_IMM, 'h0F0, 1, 7, 3), a & 32'h0000_00F0);
		emitAndStore(iType(OP_IMM, -256, 2, 6, 3), b | 32'hFFFF_FF00);
		emitAndStore(iType(OP_IMM, -1, 1, 4, 3), ~a);
		emitAndStore(iType(OP_IMM, -19, 1, 2, 3), {31'b0, $signed(a) < -32'sd19});
		emitAndStore(iType(OP_IMM, 28, 2, 1, 3), b << 28);
		emitAndStore(iType(OP_IMM, 4, 1, 5, 3), a >> 4);
		emitAndStore(iType(OP_IMM, 'h404, 1, 5, 3), $unsigned($signed(a) >>> 4)); // srai
		runProgram("alu", stalls);
	endtask

	task automatic testForwarding(input logic stalls);
		newProgram();
		emit(iType(OP_IMM, 40, 0, 0, 5));
		emit(iType(OP_IMM, 2, 5, 0, 6));    // From EX/MEM
		emit(iType(OP_IMM, 3, 5, 0, 7));    // From MEM/WB
		emit(rType(0, 6, 7, 0, 8));         // Both distances at once
		emitStore(8, 64, 32'd85);
		emit(iType(OP_LOAD, 64, 0, 2, 9));
		emit(iType(OP_IMM, 1, 9, 0, 10));   // Load-use
		emitStore(10, 68, 32'd86);
		emit(iType(OP_LOAD, 68, 0, 2, 11));
		emitStore(11, 72, 32'd86);          // Loaded value straight into store data
		emit(iType(OP_IMM, 5, 5, 0, 0));    // Write to x0 is dropped
		emit(rType(0, 5, 0, 0, 12));
		emitStore(12, 76, 32'd40);
		emitStore(0, 80, 32'd0);
		runProgram("forwarding", stalls);
	endtask

	task automatic testBranches(input logic stalls);
		int linkPc;
		int basePc;
		newProgram();
		emit(iType(OP_IMM, 5, 0, 0, 1));
		emit(iType(OP_IMM, 9, 0, 0, 3));
		emit(iType(OP_IMM, 5, 0, 0, 2));
		emit(bType(0, 1, 2, 8)); // beq taken while x2 is still in execute
		emit(sType(3, 0, 96));
		emit(bType(1, 1, 2, 8)); // bne not taken
		emitStore(1, 100, 32'd5);
		emit(bType(0, 1, 3, 8)); // beq not taken
		emitStore(3, 104, 32'd9);
		emit(bType(1, 1, 3, 8)); // bne taken
		emit(sType(1, 0, 108));
		linkPc = 4 * prog.size();
		emit(jType(4, 8));
		emit(sType(3, 0, 112));
		emitStore(4, 116, rvPkg::word_t'(linkPc + 4));
		// jalr lands past two skipped stores, target built as base plus 2
		basePc = 4 * prog.size();
		emit(iType(OP_IMM, basePc + 14, 0, 0, 6));
		emit(iType(OP_JALR, 2, 6, 0, 7));
		emit(sType(3, 0, 120));
		emit(sType(3, 0, 124));
		emitStore(7, 128, rvPkg::word_t'(basePc + 8));
		runProgram("branches", stalls);
	endtask

	initial begin
		rst_n   = 1'b0;
		stallEn = 1'b0;
		for (int i = 0; i < ROM_WORDS; i++)
			mem.rom[i[7:0]] = `RV_NOP;
		testReset();
		testAlu(1'b0);
		testForwarding(1'b0);
		testBranches(1'b0);
		// Same programs with random memory stalls
		testAlu(1'b1);
		testForwarding(1'b1);
		testBranches(1'b1);
		$display("all tests passed");
		$finish;
	end

endmodule

//--- src.f
+incdir+design
design/rvPkg.sv
design/fetchUnit.sv
design/decodeStage.sv
design/regFile.sv
design/executeStage.sv
design/riscvCore.sv
testbench/memModel.sv
testbench/coreTb.sv

//--- run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	-f src.f --top-module coreTb -Mdir obj_dir -o coreSim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/coreSim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0
